// ==== rtl/n2r_pkg.sv ====
/*
 * Matrix geometry shared by the row-to-chunk reshaping pipeline.
 * COL_COUNT must be a multiple of BLOCK_SIZE, ROW_COUNT a multiple of SLICE_ROWS.
 */
`default_nettype none

package n2r_pkg;

    // Base geometry
    localparam int ELEM_WIDTH = 16;
    localparam int ROW_COUNT  = 8;
    localparam int COL_COUNT  = 8;
    localparam int BLOCK_SIZE = 2;
    localparam int NUM_CORES  = 2;

    // Derived slice and chunk shape
    localparam int SLICE_ROWS     = BLOCK_SIZE * NUM_CORES;
    localparam int CHUNKS_PER_ROW = COL_COUNT / BLOCK_SIZE;
    localparam int SLICE_COUNT    = ROW_COUNT / SLICE_ROWS;

    localparam int ROW_WIDTH   = COL_COUNT * ELEM_WIDTH;
    localparam int BLOCK_WIDTH = BLOCK_SIZE * ELEM_WIDTH;
    localparam int CHUNK_WIDTH = SLICE_ROWS * BLOCK_WIDTH;

    localparam int ROW_ADDR_WIDTH  = $clog2(ROW_COUNT);
    localparam int SLOT_WIDTH      = $clog2(SLICE_ROWS);
    localparam int CHUNK_IDX_WIDTH = $clog2(CHUNKS_PER_ROW);
    // At least one bit, even for a single-slice matrix
    localparam int SLICE_IDX_WIDTH = (SLICE_COUNT > 1) ? $clog2(SLICE_COUNT) : 1;

endpackage

`default_nettype wire

// ==== rtl/ram_1w1r.sv ====
/*
 * Row memory with one write port and one registered read port.
 * Read-during-write to one address returns the old row. No reset on contents.
 */
`default_nettype none

module ram_1w1r import n2r_pkg::*; #(
    parameter int DEPTH = ROW_COUNT
) (
    input  logic                      clk,
    input  logic                      we,
    input  logic [ROW_ADDR_WIDTH-1:0] write_addr,
    input  logic [ROW_ADDR_WIDTH-1:0] read_addr,
    input  logic [ROW_WIDTH-1:0]      din,
    output logic [ROW_WIDTH-1:0]      dout
);

    logic [ROW_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[write_addr] <= din;
        end
        // Read sees the value from before this edge
        dout <= mem[read_addr];
    end

endmodule

`default_nettype wire

// ==== rtl/n2r_fill_stage.sv ====
/*
 * Writes ROW_COUNT rows into the store, one per cycle while en is high.
 * Ignores en after the last row until buffer_done re-arms it.
 */
`default_nettype none

module n2r_fill_stage import n2r_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      en,
    input  logic [ROW_WIDTH-1:0]      row_in,
    input  logic                      buffer_done,
    output logic                      we,
    output logic [ROW_ADDR_WIDTH-1:0] write_addr,
    output logic [ROW_WIDTH-1:0]      din,
    output logic                      fill_done
);

    typedef enum logic {
        ACCEPTING,
        FULL
    } fill_state_t;

    fill_state_t               state;
    logic [ROW_ADDR_WIDTH-1:0] row_count;
    logic                      take_row;

    assign take_row = (state == ACCEPTING) && en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ACCEPTING;
            row_count <= '0;
            we        <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            we        <= take_row;
            // One cycle after the final write lands
            fill_done <= we && (write_addr == ROW_ADDR_WIDTH'(ROW_COUNT - 1));
            if (take_row) begin
                if (row_count == ROW_ADDR_WIDTH'(ROW_COUNT - 1)) begin
                    row_count <= '0;
                    state     <= FULL;
                end else begin
                    row_count <= row_count + 1'b1;
                end
            end else if (state == FULL && buffer_done) begin
                state <= ACCEPTING;
            end
        end
    end

    // Write address and data
    always_ff @(posedge clk) begin
        if (take_row) begin
            write_addr <= row_count;
            din        <= row_in;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/n2r_slice_loader.sv ====
/*
 * Reads SLICE_ROWS consecutive rows per slice from the store.
 * Slice 0 starts on fill_done, later slices on slice_done.
 */
`default_nettype none

module n2r_slice_loader import n2r_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      fill_done,
    input  logic                      slice_done,
    output logic [ROW_ADDR_WIDTH-1:0] read_addr,
    input  logic [ROW_WIDTH-1:0]      row_rd_data,
    output logic                      row_valid,
    output logic [SLOT_WIDTH-1:0]     row_slot,
    output logic [ROW_WIDTH-1:0]      row_data
);

    logic                      active;
    logic [ROW_ADDR_WIDTH-1:0] base;
    logic [SLOT_WIDTH-1:0]     slot;
    logic                      last_slot;
    logic                      last_base;

    assign last_slot = (slot == SLOT_WIDTH'(SLICE_ROWS - 1));
    assign last_base = (base == ROW_ADDR_WIDTH'(ROW_COUNT - SLICE_ROWS));
    assign read_addr = base + ROW_ADDR_WIDTH'(slot);

    // RAM data arrives one cycle after the address
    assign row_data = row_rd_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active    <= 1'b0;
            base      <= '0;
            slot      <= '0;
            row_valid <= 1'b0;
        end else begin
            row_valid <= active;
            if (active) begin
                if (last_slot) begin
                    slot   <= '0;
                    active <= 1'b0;
                end else begin
                    slot <= slot + 1'b1;
                end
            end
            if (fill_done) begin
                active <= 1'b1;
            end else if (slice_done) begin
                if (last_base) begin
                    // Whole matrix read, wait for the next fill
                    base <= '0;
                end else begin
                    base   <= base + ROW_ADDR_WIDTH'(SLICE_ROWS);
                    active <= 1'b1;
                end
            end
        end
    end

    // Slot index follows the read by one cycle
    always_ff @(posedge clk) begin
        row_slot <= slot;
    end

endmodule

`default_nettype wire

// ==== rtl/n2r_chunk_emitter.sv ====
/*
 * Holds one slice and emits CHUNKS_PER_ROW chunks on consecutive cycles.
 * No stall input; a new slice must not arrive while chunks are going out.
 */
`default_nettype none

module n2r_chunk_emitter import n2r_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   row_valid,
    input  logic [SLOT_WIDTH-1:0]  row_slot,
    input  logic [ROW_WIDTH-1:0]   row_data,
    output logic [CHUNK_WIDTH-1:0] chunk_out,
    output logic                   output_ready,
    output logic                   slice_done,
    output logic                   buffer_done
);

    logic [ROW_WIDTH-1:0]       slot_rows [SLICE_ROWS];
    logic                       emitting;
    logic [CHUNK_IDX_WIDTH-1:0] chunk_idx;
    logic [SLICE_IDX_WIDTH-1:0] slice_idx;
    logic                       slice_loaded;
    logic                       last_chunk;
    logic                       last_slice;

    assign slice_loaded = row_valid && (row_slot == SLOT_WIDTH'(SLICE_ROWS - 1));
    assign last_chunk   = (chunk_idx == CHUNK_IDX_WIDTH'(CHUNKS_PER_ROW - 1));
    assign last_slice   = (slice_idx == SLICE_IDX_WIDTH'(SLICE_COUNT - 1));

    // Slice rows
    always_ff @(posedge clk) begin
        if (row_valid) begin
            slot_rows[row_slot] <= row_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            emitting  <= 1'b0;
            chunk_idx <= '0;
            slice_idx <= '0;
        end else if (slice_loaded) begin
            emitting  <= 1'b1;
            chunk_idx <= '0;
        end else if (emitting) begin
            if (last_chunk) begin
                emitting  <= 1'b0;
                chunk_idx <= '0;
                slice_idx <= last_slice ? '0 : slice_idx + 1'b1;
            end else begin
                chunk_idx <= chunk_idx + 1'b1;
            end
        end
    end

    // Lane i takes row i of the slice, block chunk_idx, MSB lane first
    always_comb begin
        chunk_out = '0;
        for (int lane = 0; lane < SLICE_ROWS; lane++) begin
            chunk_out[CHUNK_WIDTH - 1 - lane * BLOCK_WIDTH -: BLOCK_WIDTH] =
                slot_rows[lane][ROW_WIDTH - 1 - int'(chunk_idx) * BLOCK_WIDTH -: BLOCK_WIDTH];
        end
    end

    assign output_ready = emitting;
    assign slice_done   = emitting && last_chunk;
    assign buffer_done  = slice_done && last_slice;

endmodule

`default_nettype wire

// ==== rtl/n2r_buffer.sv ====
/*
 * Reshapes a row-ordered matrix into column chunks for the multiply array.
 * First chunk comes 6 cycles after fill_done. Output cannot be stalled.
 */
`default_nettype none

module n2r_buffer import n2r_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic [ROW_WIDTH-1:0]   row_in,
    output logic [CHUNK_WIDTH-1:0] chunk_out,
    output logic                   output_ready,
    output logic                   slice_done,
    output logic                   buffer_done
);

    logic                      we;
    logic [ROW_ADDR_WIDTH-1:0] write_addr;
    logic [ROW_ADDR_WIDTH-1:0] read_addr;
    logic [ROW_WIDTH-1:0]      din;
    logic [ROW_WIDTH-1:0]      dout;
    logic                      fill_done;
    logic                      row_valid;
    logic [SLOT_WIDTH-1:0]     row_slot;
    logic [ROW_WIDTH-1:0]      row_data;

    n2r_fill_stage u_fill (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .row_in      (row_in),
        .buffer_done (buffer_done),
        .we          (we),
        .write_addr  (write_addr),
        .din         (din),
        .fill_done   (fill_done)
    );

    ram_1w1r #(
        .DEPTH (ROW_COUNT)
    ) u_store (
        .clk        (clk),
        .we         (we),
        .write_addr (write_addr),
        .read_addr  (read_addr),
        .din        (din),
        .dout       (dout)
    );

    n2r_slice_loader u_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .fill_done   (fill_done),
        .slice_done  (slice_done),
        .read_addr   (read_addr),
        .row_rd_data (dout),
        .row_valid   (row_valid),
        .row_slot    (row_slot),
        .row_data    (row_data)
    );

    n2r_chunk_emitter u_emit (
        .clk          (clk),
        .rst_n        (rst_n),
        .row_valid    (row_valid),
        .row_slot     (row_slot),
        .row_data     (row_data),
        .chunk_out    (chunk_out),
        .output_ready (output_ready),
        .slice_done   (slice_done),
        .buffer_done  (buffer_done)
    );

endmodule

`default_nettype wire

// ==== test/n2r_buffer_properties.sv ====
/*
 * Flag checks on the n2r_buffer outputs, bound into every n2r_buffer.
 */
`default_nettype none

module n2r_buffer_properties import n2r_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic output_ready,
    input logic slice_done,
    input logic buffer_done
);
    timeunit 1ns;
    timeprecision 1ps;

    int run_len;

    // Length of the current output_ready run
    always_ff @(posedge clk) begin
        if (!rst_n || !output_ready) begin
            run_len <= 0;
        end else begin
            run_len <= run_len + 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) slice_done |-> output_ready)
        else $error("slice_done high without output_ready");
    assert property (@(posedge clk) disable iff (!rst_n) buffer_done |-> slice_done)
        else $error("buffer_done high without slice_done");
    assert property (@(posedge clk) !rst_n |=> !output_ready)
        else $error("output_ready high in the cycle after reset");
    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(output_ready) |-> run_len == CHUNKS_PER_ROW)
        else $error("output_ready run shorter than one slice");
    assert property (@(posedge clk) disable iff (!rst_n)
        output_ready |-> run_len < CHUNKS_PER_ROW)
        else $error("output_ready run longer than one slice");

endmodule

bind n2r_buffer n2r_buffer_properties u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .output_ready (output_ready),
    .slice_done   (slice_done),
    .buffer_done  (buffer_done)
);

`default_nettype wire

// ==== test/tb_n2r_buffer.sv ====
/*
 * Testbench for n2r_buffer. Expected chunks are built from the chunk rule.
 * Rows offered while the buffer is full carry a 0xbad pattern and must never come out.
 */
`default_nettype none

module tb_n2r_buffer import n2r_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] MODE_INC  = 2'd0;
    localparam logic [1:0] MODE_LFSR = 2'd1;
    localparam logic [1:0] MODE_ZERO = 2'd2;
    localparam int NUM_ENTRIES  = 6;
    localparam int TOTAL_CHUNKS = SLICE_COUNT * CHUNKS_PER_ROW;
    localparam int DONE_TIMEOUT = 64;

    // Data mode, then one idle cycle after every gap rows (0 is no gap)
    typedef struct packed {
        logic [1:0] mode;
        logic [3:0] gap;
    } entry_t;

    localparam entry_t ENTRIES [NUM_ENTRIES] = '{
        '{MODE_INC, 4'd0}, '{MODE_LFSR, 4'd0}, '{MODE_ZERO, 4'd3},
        '{MODE_LFSR, 4'd1}, '{MODE_INC, 4'd2}, '{MODE_ZERO, 4'd0}
    };

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   en;
    logic [ROW_WIDTH-1:0]   row_in;
    logic [CHUNK_WIDTH-1:0] chunk_out;
    logic                   output_ready;
    logic                   slice_done;
    logic                   buffer_done;

    logic [ELEM_WIDTH-1:0]  elem [ROW_COUNT][COL_COUNT];
    logic [CHUNK_WIDTH-1:0] chunk_q [$];
    logic                   slice_q [$];
    logic                   bdone_q [$];
    logic [31:0]            lfsr_state = 32'h91c7;
    int                     done_count = 0;
    int                     errors = 0;
    int                     entries_run = 0;
    bit                     timed_out = 1'b0;

    n2r_buffer u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .row_in       (row_in),
        .chunk_out    (chunk_out),
        .output_ready (output_ready),
        .slice_done   (slice_done),
        .buffer_done  (buffer_done)
    );

    always #4 clk = ~clk;

    // Chunk monitor samples in mid-cycle
    always @(negedge clk) begin
        if (rst_n && output_ready) begin
            chunk_q.push_back(chunk_out);
            slice_q.push_back(slice_done);
            bdone_q.push_back(buffer_done);
            if (buffer_done) begin
                done_count++;
            end
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [ELEM_WIDTH-1:0] random_elem();
        logic [ELEM_WIDTH-1:0] v;
        v = '0;
        for (int b = 0; b < ELEM_WIDTH; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[ELEM_WIDTH-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Column 0 lands at the MSB end
    function automatic logic [ROW_WIDTH-1:0] row_of(input int r);
        logic [ROW_WIDTH-1:0] row;
        row = '0;
        for (int c = 0; c < COL_COUNT; c++) begin
            row = {row[ROW_WIDTH-ELEM_WIDTH-1:0], elem[r][c]};
        end
        return row;
    endfunction

    // Lane 0 first, column 2k above column 2k+1
    function automatic logic [CHUNK_WIDTH-1:0] expected_chunk(input int slice, input int k);
        logic [CHUNK_WIDTH-1:0] chunk;
        chunk = '0;
        for (int i = 0; i < SLICE_ROWS; i++) begin
            for (int j = 0; j < BLOCK_SIZE; j++) begin
                chunk = {chunk[CHUNK_WIDTH-ELEM_WIDTH-1:0],
                         elem[slice * SLICE_ROWS + i][k * BLOCK_SIZE + j]};
            end
        end
        return chunk;
    endfunction

    task automatic build_matrix(input int entry, input logic [1:0] mode);
        int zero_row;
        int zero_col;
        zero_row = (entry * 3) % ROW_COUNT;
        zero_col = (entry * 5 + 1) % COL_COUNT;
        for (int r = 0; r < ROW_COUNT; r++) begin
            for (int c = 0; c < COL_COUNT; c++) begin
                if (mode == MODE_INC) begin
                    elem[r][c] = ELEM_WIDTH'(entry * 64 + r * COL_COUNT + c + 1);
                end else if (mode == MODE_LFSR) begin
                    elem[r][c] = random_elem();
                end else begin
                    elem[r][c] = (r == zero_row && c == zero_col) ? '0 : '1;
                end
            end
        end
    endtask

    task automatic drive_matrix(input int gap);
        for (int r = 0; r < ROW_COUNT; r++) begin
            if (gap > 0 && r > 0 && (r % gap) == 0) begin
                @(posedge clk);
                #1;
                en = 1'b0;
            end
            @(posedge clk);
            #1;
            en = 1'b1;
            row_in = row_of(r);
        end
    endtask

    // Keeps offering rows until buffer_done re-arms the fill stage
    task automatic offer_extras_until_done();
        int start_count;
        int cycles;
        start_count = done_count;
        cycles = 0;
        while (done_count == start_count && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            en = 1'b1;
            row_in = {COL_COUNT{16'hbad0 | ELEM_WIDTH'(cycles % 16)}};
            cycles++;
        end
        en = 1'b0;
        if (done_count == start_count) begin
            $display("Timed out after %0d cycles waiting for buffer_done", DONE_TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_matrix();
        logic [CHUNK_WIDTH-1:0] expected;
        logic                   exp_slice;
        logic                   exp_done;
        assert (chunk_q.size() == TOTAL_CHUNKS) else begin
            $display("[FAIL] output_ready chunks: got %h expected %h",
                     chunk_q.size(), TOTAL_CHUNKS);
            errors++;
        end
        for (int n = 0; n < chunk_q.size() && n < TOTAL_CHUNKS; n++) begin
            expected  = expected_chunk(n / CHUNKS_PER_ROW, n % CHUNKS_PER_ROW);
            exp_slice = (n % CHUNKS_PER_ROW) == CHUNKS_PER_ROW - 1;
            exp_done  = n == TOTAL_CHUNKS - 1;
            assert (chunk_q[n] == expected) else begin
                $display("[FAIL] chunk_out #%0d: got %h expected %h", n, chunk_q[n], expected);
                errors++;
            end
            assert (slice_q[n] == exp_slice) else begin
                $display("[FAIL] slice_done #%0d: got %h expected %h", n, slice_q[n], exp_slice);
                errors++;
            end
            assert (bdone_q[n] == exp_done) else begin
                $display("[FAIL] buffer_done #%0d: got %h expected %h", n, bdone_q[n], exp_done);
                errors++;
            end
        end
    endtask

    initial begin
        int errors_before;
        rst_n = 1'b0;
        en = 1'b0;
        row_in = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        assert (chunk_q.size() == 0 && !output_ready && !slice_done && !buffer_done) else begin
            $display("Output went active after reset with no matrix supplied");
            errors++;
        end
        for (int e = 0; e < NUM_ENTRIES && !timed_out; e++) begin
            errors_before = errors;
            build_matrix(e, ENTRIES[e].mode);
            drive_matrix(int'(ENTRIES[e].gap));
            assert (chunk_q.size() == 0) else begin
                $display("Chunks came out before the matrix was complete");
                errors++;
            end
            offer_extras_until_done();
            if (!timed_out) begin
                check_matrix();
            end
            entries_run++;
            $display("entry %0d mode %0d gap %0d: %0d chunks, %0d errors", e,
                     ENTRIES[e].mode, ENTRIES[e].gap, chunk_q.size(), errors - errors_before);
            chunk_q.delete();
            slice_q.delete();
            bdone_q.delete();
        end
        repeat (10) @(posedge clk);
        #1;
        assert (chunk_q.size() == 0) else begin
            $display("Chunks came out with no matrix pending");
            errors++;
        end
        $display("entries %0d of %0d, errors %0d", entries_run, NUM_ENTRIES, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/n2r_pkg.sv
rtl/ram_1w1r.sv
rtl/n2r_fill_stage.sv
rtl/n2r_slice_loader.sv
rtl/n2r_chunk_emitter.sv
rtl/n2r_buffer.sv
test/n2r_buffer_properties.sv
test/tb_n2r_buffer.sv

// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = tb_n2r_buffer
FLIST = flist.f
OBJ   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee /dev/stderr | grep -x "Test OK" > /dev/null

clean:
	rm -rf $(OBJ)
